/* hw/reg_xing_pkg.sv */
// Register crossing shared definitions
`default_nettype none

package reg_xing_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 8;              // Register word address
    localparam int DATA_W = 32;             // Register and data width
    localparam int STRB_W = DATA_W / 8;     // One strobe per byte lane

    // Number of implemented register words
    localparam int NUM_REGS = 16;

    // Flops in each req/ack synchronizer chain
    localparam int SYNC_STAGES = 3;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [ADDR_W-1:0] REG_ID    = 8'd0;  // Read-only identification
    localparam logic [ADDR_W-1:0] REG_COUNT = 8'd1;  // Read-only command counter

    // Value returned by a read of REG_ID
    localparam logic [DATA_W-1:0] ID_VALUE = 32'h5247_0001;

    // ----------------------------------------
    // Payload types
    // ----------------------------------------

    // Command from host to register bank, 45 bits
    typedef struct packed {
        logic              write;   // 1 = write, 0 = read
        logic [ADDR_W-1:0] addr;    // Word address
        logic [DATA_W-1:0] wdata;   // Write data
        logic [STRB_W-1:0] wstrb;   // Byte enables for writes
    } cmd_t;

    // Response from register bank to host, 33 bits
    typedef struct packed {
        logic [DATA_W-1:0] rdata;   // Read data, zero on writes and errors
        logic              err;     // Bad address or write to read-only
    } rsp_t;

endpackage : reg_xing_pkg

`default_nettype wire

/* hw/cdc_handshake.sv */
// Valid/ready clock domain crossing
`timescale 1ns/1ps
`default_nettype none

module cdc_handshake #(
    parameter type payload_t = logic [31:0]   // Item carried across
) (
    // Source side
    input  logic     clk_src,     // Source domain clock
    input  logic     rst_src_n,   // Source domain reset, async active low
    input  logic     src_valid,   // Item offered by source
    output logic     src_ready,   // Crossing can take an item
    input  payload_t src_data,    // Item from source

    // Destination side
    input  logic     clk_dst,     // Destination domain clock
    input  logic     rst_dst_n,   // Destination domain reset, async active low
    output logic     dst_valid,   // Item presented to receiver
    input  logic     dst_ready,   // Receiver takes the item
    output payload_t dst_data     // Item in destination domain
);

    // ----------------------------------------
    // Declarations
    // ----------------------------------------

    // Handshake flags, each owned by one domain
    logic req_src;                // Source request, clk_src
    logic ack_dst;                // Destination acknowledge, clk_dst

    // Captured item, held constant while req_src is high
    payload_t hold_data;

    // Synchronizer chains, oldest stage at the top
    logic [reg_xing_pkg::SYNC_STAGES-1:0] req_sync;   // req_src into clk_dst
    logic [reg_xing_pkg::SYNC_STAGES-1:0] ack_sync;   // ack_dst into clk_src

    logic req_seen;               // Synchronized request in clk_dst
    logic ack_seen;               // Synchronized acknowledge in clk_src

    logic src_xfer;               // Source side transfer this cycle
    logic dst_xfer;               // Destination side transfer this cycle

    typedef enum logic [1:0] {
        S_IDLE,                   // Free, waiting for src_valid
        S_WAIT_ACK,               // Request up, item in flight
        S_WAIT_ACK_CLR            // Request down, waiting for ack to fall
    } src_state_t;

    typedef enum logic [1:0] {
        D_IDLE,                   // Waiting for a request
        D_WAIT_READY,             // Item presented, waiting for receiver
        D_WAIT_REQ_CLR            // Ack up, waiting for request to fall
    } dst_state_t;

    src_state_t src_state;
    dst_state_t dst_state;

    assign src_xfer = src_valid && src_ready;
    assign dst_xfer = dst_valid && dst_ready;

    // ----------------------------------------
    // Acknowledge synchronizer, clk_src
    // ----------------------------------------
    always_ff @(posedge clk_src or negedge rst_src_n) begin
        if (!rst_src_n) begin
            ack_sync <= '0;
        end else begin
            ack_sync <= {ack_sync[reg_xing_pkg::SYNC_STAGES-2:0], ack_dst};
        end
    end

    assign ack_seen = ack_sync[reg_xing_pkg::SYNC_STAGES-1];

    // ----------------------------------------
    // Source FSM, clk_src
    // ----------------------------------------
    // src_ready is a flop, so it never looks at src_valid in the same cycle
    always_ff @(posedge clk_src or negedge rst_src_n) begin
        if (!rst_src_n) begin
            src_state <= S_IDLE;
            req_src   <= 1'b0;
            src_ready <= 1'b0;   // Comes up one cycle after release
        end else begin
            case (src_state)
                S_IDLE: begin
                    if (src_xfer) begin
                        req_src   <= 1'b1;          // Phase 1, raise req
                        src_ready <= 1'b0;          // One item at a time
                        src_state <= S_WAIT_ACK;
                    end else begin
                        src_ready <= 1'b1;
                    end
                end
                S_WAIT_ACK: begin
                    if (ack_seen) begin
                        req_src   <= 1'b0;          // Phase 3, drop req
                        src_state <= S_WAIT_ACK_CLR;
                    end
                end
                S_WAIT_ACK_CLR: begin
                    // Ack gone means destination is back in idle
                    if (!ack_seen) begin
                        src_ready <= 1'b1;
                        src_state <= S_IDLE;
                    end
                end
                default: begin
                    req_src   <= 1'b0;
                    src_ready <= 1'b0;
                    src_state <= S_IDLE;
                end
            endcase
        end
    end

    // Item capture, only on a source transfer
    always_ff @(posedge clk_src) begin
        if (src_xfer) begin
            hold_data <= src_data;
        end
    end

    // ----------------------------------------
    // Request synchronizer, clk_dst
    // ----------------------------------------
    always_ff @(posedge clk_dst or negedge rst_dst_n) begin
        if (!rst_dst_n) begin
            req_sync <= '0;
        end else begin
            req_sync <= {req_sync[reg_xing_pkg::SYNC_STAGES-2:0], req_src};
        end
    end

    assign req_seen = req_sync[reg_xing_pkg::SYNC_STAGES-1];

    // ----------------------------------------
    // Destination FSM, clk_dst
    // ----------------------------------------
    always_ff @(posedge clk_dst or negedge rst_dst_n) begin
        if (!rst_dst_n) begin
            dst_state <= D_IDLE;
            ack_dst   <= 1'b0;
            dst_valid <= 1'b0;
        end else begin
            case (dst_state)
                D_IDLE: begin
                    if (req_seen) begin
                        dst_valid <= 1'b1;          // hold_data is stable by now
                        dst_state <= D_WAIT_READY;
                    end
                end
                D_WAIT_READY: begin
                    // Back-pressure just parks here with ack low
                    if (dst_xfer) begin
                        dst_valid <= 1'b0;
                        ack_dst   <= 1'b1;          // Phase 2, raise ack
                        dst_state <= D_WAIT_REQ_CLR;
                    end
                end
                D_WAIT_REQ_CLR: begin
                    if (!req_seen) begin
                        ack_dst   <= 1'b0;          // Phase 4, drop ack
                        dst_state <= D_IDLE;
                    end
                end
                default: begin
                    ack_dst   <= 1'b0;
                    dst_valid <= 1'b0;
                    dst_state <= D_IDLE;
                end
            endcase
        end
    end

    // Latch item when the request is first seen
    always_ff @(posedge clk_dst) begin
        if (dst_state == D_IDLE && req_seen) begin
            dst_data <= hold_data;
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------

    // Captured item must not move while the other domain may sample it
    a_hold_stable : assert property (
        @(posedge clk_src) disable iff (!rst_src_n)
        req_src |=> (!req_src || $stable(hold_data))
    );

    // Receiver sees a steady item until it takes it
    a_dst_stable : assert property (
        @(posedge clk_dst) disable iff (!rst_dst_n)
        (dst_valid && !dst_ready) |=> (dst_valid && $stable(dst_data))
    );

endmodule : cdc_handshake

`default_nettype wire

/* hw/reg_bank.sv */
// Register bank in the destination domain
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  logic                clk_dst,     // Destination domain clock
    input  logic                rst_n,       // Asynchronous active-low reset

    // Command in
    input  logic                cmd_valid,
    output logic                cmd_ready,   // High whenever no response is pending
    input  reg_xing_pkg::cmd_t  cmd,

    // Response out
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output reg_xing_pkg::rsp_t  rsp
);

    // ----------------------------------------
    // Declarations
    // ----------------------------------------

    // Writable words at addresses 2 and up
    logic [reg_xing_pkg::DATA_W-1:0] regs [2:reg_xing_pkg::NUM_REGS-1];

    // Commands accepted so far
    logic [reg_xing_pkg::DATA_W-1:0] cmd_count;

    logic [$clog2(reg_xing_pkg::NUM_REGS)-1:0] reg_idx;  // Low address bits

    logic accept;                 // Command transfer this cycle
    logic addr_hit;               // Address inside the map
    logic ro_hit;                 // Address is ID or counter
    logic wr_en;                  // Legal write to a storage word

    reg_xing_pkg::rsp_t rsp_next;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    assign cmd_ready = !rsp_valid;   // Single command in flight
    assign accept    = cmd_valid && cmd_ready;

    assign reg_idx  = cmd.addr[$clog2(reg_xing_pkg::NUM_REGS)-1:0];
    assign addr_hit = (cmd.addr < reg_xing_pkg::ADDR_W'(reg_xing_pkg::NUM_REGS));
    assign ro_hit   = (cmd.addr == reg_xing_pkg::REG_ID) ||
                      (cmd.addr == reg_xing_pkg::REG_COUNT);
    assign wr_en    = accept && cmd.write && addr_hit && !ro_hit;

    // Response for the command on the input
    always_comb begin
        rsp_next = '0;
        if (!addr_hit) begin
            rsp_next.err = 1'b1;                // Out of map with rdata left at zero
        end else if (cmd.write) begin
            rsp_next.err = ro_hit;              // Writes never return data
        end else if (cmd.addr == reg_xing_pkg::REG_ID) begin
            rsp_next.rdata = reg_xing_pkg::ID_VALUE;
        end else if (cmd.addr == reg_xing_pkg::REG_COUNT) begin
            rsp_next.rdata = cmd_count;         // Count before this command
        end else begin
            rsp_next.rdata = regs[reg_idx];
        end
    end

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk_dst or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            cmd_count <= '0;
        end else begin
            if (accept) begin
                rsp_valid <= 1'b1;                  // Response one cycle later
                cmd_count <= cmd_count + reg_xing_pkg::DATA_W'(1);  // Errors count too
            end else if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk_dst) begin
        if (accept) begin
            rsp <= rsp_next;
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    // Byte-lane merge under wstrb
    always_ff @(posedge clk_dst or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 2; r < reg_xing_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < reg_xing_pkg::STRB_W; b++) begin
                if (cmd.wstrb[b]) begin
                    regs[reg_idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------

    // Pending response holds until the crossing takes it
    a_rsp_hold : assert property (
        @(posedge clk_dst) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    );

endmodule : reg_bank

`default_nettype wire

/* hw/reg_xing.sv */
// Register access bridge top level
`timescale 1ns/1ps
`default_nettype none

module reg_xing (
    input  logic                clk_src,     // Host domain clock
    input  logic                clk_dst,     // Register bank clock
    input  logic                rst_n,       // Async reset for both domains

    // Host command port, clk_src
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  reg_xing_pkg::cmd_t  cmd,

    // Host response port, clk_src
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output reg_xing_pkg::rsp_t  rsp
);

    // ----------------------------------------
    // Bank side of both crossings, clk_dst
    // ----------------------------------------
    logic               bank_cmd_valid;
    logic               bank_cmd_ready;
    reg_xing_pkg::cmd_t bank_cmd;

    logic               bank_rsp_valid;
    logic               bank_rsp_ready;
    reg_xing_pkg::rsp_t bank_rsp;

    // Host to bank
    cdc_handshake #(.payload_t(reg_xing_pkg::cmd_t)) cmd_xing (
        .clk_src   (clk_src),
        .rst_src_n (rst_n),
        .src_valid (cmd_valid),
        .src_ready (cmd_ready),
        .src_data  (cmd),
        .clk_dst   (clk_dst),
        .rst_dst_n (rst_n),
        .dst_valid (bank_cmd_valid),
        .dst_ready (bank_cmd_ready),
        .dst_data  (bank_cmd)
    );

    reg_bank u_reg_bank (
        .clk_dst   (clk_dst),
        .rst_n     (rst_n),
        .cmd_valid (bank_cmd_valid),
        .cmd_ready (bank_cmd_ready),
        .cmd       (bank_cmd),
        .rsp_valid (bank_rsp_valid),
        .rsp_ready (bank_rsp_ready),
        .rsp       (bank_rsp)
    );

    // Bank back to host, clocks swapped
    cdc_handshake #(.payload_t(reg_xing_pkg::rsp_t)) rsp_xing (
        .clk_src   (clk_dst),
        .rst_src_n (rst_n),
        .src_valid (bank_rsp_valid),
        .src_ready (bank_rsp_ready),
        .src_data  (bank_rsp),
        .clk_dst   (clk_src),
        .rst_dst_n (rst_n),
        .dst_valid (rsp_valid),
        .dst_ready (rsp_ready),
        .dst_data  (rsp)
    );

endmodule : reg_xing

`default_nettype wire

/* sim/reg_xing_tests.svh */
// Directed tests for the register crossing

// Reset values, then cmd_ready comes up with no stray response
task automatic test_reset_state();
    int n;
    repeat (16) @(negedge clk_src);                   // Reset held since time zero
    if (cmd_ready !== 1'b0) mismatch("cmd_ready high during reset");
    if (rsp_valid !== 1'b0) mismatch("rsp_valid high during reset");
    rst_n = 1'b1;
    n = 0;
    while (!cmd_ready && n < WAIT_LIMIT) begin
        @(negedge clk_src);
        if (rsp_valid !== 1'b0) mismatch("rsp_valid high before any command");
        n++;
    end
    if (!cmd_ready) note_timeout("cmd_ready after reset");
    repeat (10) begin
        @(negedge clk_src);
        if (rsp_valid !== 1'b0) mismatch("rsp_valid high before any command");
    end
    finish_test("reset");
endtask

task automatic test_id_count();
    transact(make_cmd(1'b0, reg_xing_pkg::REG_ID, '0, '0), 0);
    transact(make_cmd(1'b0, reg_xing_pkg::REG_COUNT, '0, '0), 0);
    finish_test("id_count");
endtask

// ----------------------------------------
// Storage words, full words then random strobes
task automatic test_read_write();
    logic [7:0] addr;
    for (int i = 0; i < 8; i++) begin
        addr = 8'(2 + next_rand() % 32'd14);
        transact(make_cmd(1'b1, addr, next_rand(), 4'hf), 0);
        transact(make_cmd(1'b0, addr, '0, '0), 0);
    end
    for (int i = 0; i < 8; i++) begin
        addr = 8'(2 + next_rand() % 32'd14);
        transact(make_cmd(1'b1, addr, next_rand(), 4'(next_rand())), 0);  // Byte merge
        transact(make_cmd(1'b0, addr, '0, '0), 0);
    end
    finish_test("read_write");
endtask

// Read-only writes and out-of-map accesses, then nothing moved
task automatic test_errors_ro();
    transact(make_cmd(1'b1, reg_xing_pkg::REG_ID, next_rand(), 4'hf), 0);
    transact(make_cmd(1'b1, reg_xing_pkg::REG_COUNT, next_rand(), 4'hf), 0);
    transact(make_cmd(1'b0, 8'(16 + next_rand() % 32'd240), '0, '0), 0);
    transact(make_cmd(1'b1, 8'(16 + next_rand() % 32'd240), next_rand(), 4'hf), 0);
    transact(make_cmd(1'b0, reg_xing_pkg::REG_ID, '0, '0), 0);
    transact(make_cmd(1'b0, reg_xing_pkg::REG_COUNT, '0, '0), 0);  // All counted
    // High addresses must not alias onto storage
    for (int a = 2; a < reg_xing_pkg::NUM_REGS; a++) begin
        transact(make_cmd(1'b0, 8'(a), '0, '0), 0);
    end
    finish_test("errors");
endtask

// ----------------------------------------
// Response held in rsp_xing by rsp_ready low
task automatic test_backpressure();
    logic [7:0] addr;
    int hold;
    for (int i = 0; i < 4; i++) begin
        addr = 8'(2 + next_rand() % 32'd14);
        hold = int'(5 + next_rand() % 32'd36);
        transact(make_cmd(1'b1, addr, next_rand(), 4'(next_rand())), hold);
        hold = int'(5 + next_rand() % 32'd36);
        transact(make_cmd(1'b0, addr, '0, '0), hold);
    end
    finish_test("backpressure");
endtask

// Back-to-back mixed traffic, some of it outside the map
task automatic test_burst();
    logic [31:0] r;
    for (int i = 0; i < 50; i++) begin
        r = next_rand();
        transact(make_cmd(r[0], 8'(next_rand() % 32'd18), next_rand(), 4'(next_rand())), 0);
    end
    finish_test("burst");
endtask

/* sim/reg_xing_tb.sv */
// Register crossing testbench
`timescale 1ns/1ps
`default_nettype none

module reg_xing_tb;

    localparam int WAIT_LIMIT = 400;          // clk_src cycles allowed per wait

    logic               clk_src = 1'b0;
    logic               clk_dst = 1'b0;
    logic               rst_n;
    logic               cmd_valid;
    logic               cmd_ready;
    reg_xing_pkg::cmd_t cmd;
    logic               rsp_valid;
    logic               rsp_ready;
    reg_xing_pkg::rsp_t rsp;

    // ----------------------------------------
    // Reference model and bookkeeping
    logic [reg_xing_pkg::DATA_W-1:0] model_regs [0:reg_xing_pkg::NUM_REGS-1];
    logic [reg_xing_pkg::DATA_W-1:0] model_count;   // Commands accepted so far

    logic [31:0] rng_state    = 32'h3eb7;
    int          test_errors  = 0;                  // Errors in the running test
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          timed_out    = 1'b0;               // Skips all later traffic

    always #2 clk_src = ~clk_src;   // 4 ns host clock
    always #3 clk_dst = ~clk_dst;   // 6 ns bank clock, unrelated

    reg_xing reg_xing_i (
        .clk_src   (clk_src),
        .clk_dst   (clk_dst),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic reg_xing_pkg::cmd_t make_cmd(input logic write,
            input logic [7:0] addr, input logic [31:0] wdata, input logic [3:0] wstrb);
        reg_xing_pkg::cmd_t c;
        c.write = write;
        c.addr  = addr;
        c.wdata = wdata;
        c.wstrb = wstrb;
        return c;
    endfunction

    // Expected response from the register map rules, model updated as a side effect
    function automatic reg_xing_pkg::rsp_t apply_model(input reg_xing_pkg::cmd_t c);
        reg_xing_pkg::rsp_t exp;
        int a;
        exp = '0;
        a   = int'(c.addr);
        if (a >= reg_xing_pkg::NUM_REGS) begin
            exp.err = 1'b1;                           // Outside the map
        end else if (c.addr == reg_xing_pkg::REG_ID || c.addr == reg_xing_pkg::REG_COUNT) begin
            if (c.write) exp.err = 1'b1;              // Read-only pair
            else if (c.addr == reg_xing_pkg::REG_ID) exp.rdata = reg_xing_pkg::ID_VALUE;
            else exp.rdata = model_count;             // Count before this one
        end else if (c.write) begin
            for (int b = 0; b < reg_xing_pkg::STRB_W; b++) begin
                if (c.wstrb[b]) model_regs[a][8*b +: 8] = c.wdata[8*b +: 8];
            end
        end else begin
            exp.rdata = model_regs[a];
        end
        model_count = model_count + 1;                // Errors count too
        return exp;
    endfunction

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t ns: %s did not rise in time", $time, what);
        test_errors++;
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("Test %-14s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        test_errors = 0;
    endtask

    // ----------------------------------------
    // One command, response held off for hold cycles
    task automatic transact(input reg_xing_pkg::cmd_t c, input int hold);
        reg_xing_pkg::rsp_t exp;
        reg_xing_pkg::rsp_t got;
        int n;
        if (timed_out) return;
        exp = apply_model(c);
        @(negedge clk_src);
        cmd_valid = 1'b1;
        cmd       = c;
        n = 0;
        while (!cmd_ready && n < WAIT_LIMIT) begin
            @(negedge clk_src);
            n++;
        end
        if (!cmd_ready) begin
            note_timeout("cmd_ready");
            cmd_valid = 1'b0;
            return;
        end
        @(negedge clk_src);                           // Transfer on the edge between
        cmd_valid = 1'b0;
        n = 0;
        while (!rsp_valid && n < WAIT_LIMIT) begin
            @(negedge clk_src);
            n++;
        end
        if (!rsp_valid) begin
            note_timeout("rsp_valid");
            return;
        end
        got = rsp;
        repeat (hold) begin
            @(negedge clk_src);
            if (!rsp_valid) mismatch("rsp_valid dropped while rsp_ready low");
            if (rsp !== got) mismatch("rsp changed while rsp_ready low");
        end
        rsp_ready = 1'b1;
        @(negedge clk_src);
        rsp_ready = 1'b0;
        if (got !== exp) begin
            mismatch($sformatf("addr %0d write %b: got rdata %h err %b, expected %h err %b",
                     c.addr, c.write, got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    `include "reg_xing_tests.svh"

    initial begin
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_ready   = 1'b0;
        model_count = '0;
        for (int r = 0; r < reg_xing_pkg::NUM_REGS; r++) model_regs[r] = '0;

        test_reset_state();
        test_id_count();
        test_read_write();
        test_errors_ro();
        test_backpressure();
        test_burst();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : reg_xing_tb

`default_nettype wire

/* reg_xing.f */
+incdir+sim
hw/reg_xing_pkg.sv
hw/cdc_handshake.sv
hw/reg_bank.sv
hw/reg_xing.sv
sim/reg_xing_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reg_xing testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module reg_xing_tb -f reg_xing.f \
    > "$LOG" 2>&1 &&
    ./obj_dir/Vreg_xing_tb >> "$LOG" 2>&1

grep -q "^Simulation passed$" "$LOG" && echo "PASS, see $LOG" || {
    echo "FAIL, see $LOG"
    exit 1
}
